/* jesd_tx_pkg.sv */
// JESD204 transmit package.
// Lane geometry defaults, octet and code group widths, and the K28.5 constants
// shared by the transmit datapath stages.

package jesd_tx_pkg;

  // Default link geometry.
  localparam int NUM_LANES_DEF = 4;         // Lanes.
  localparam int DPW_DEF       = 4;         // Octets per lane per clock.

  // Character widths.
  localparam int OCTET_W  = 8;              // Unencoded octet.
  localparam int SYMBOL_W = 10;             // 8b/10b code group.

  typedef logic [OCTET_W-1:0]  octet_t;     // One octet, HGFEDCBA.
  typedef logic [SYMBOL_W-1:0] symbol_t;    // One code group, a at bit 0.

  // Comma character used for code group synchronization.
  localparam octet_t K28_5 = 8'hBC;         // K28.5 octet value.

  // K28.5 code groups, bits j h g f i e d c b a from msb to lsb.
  // RD- is 001111 1010 on the line, RD+ is its complement.
  localparam symbol_t K28_5_RDN = 10'b0101111100; // Sent at negative disparity.
  localparam symbol_t K28_5_RDP = 10'b1010000011; // Sent at positive disparity.

endpackage

/* jesd_8b10b_encoder.sv */
// 8b/10b encoder for one octet.
// Combinational 5b/6b and 3b/4b lookup with running disparity in and out.
// Disparity is 0 for RD- and 1 for RD+.

`timescale 1ns/10ps

module jesd_8b10b_encoder (
  input  jesd_tx_pkg::octet_t  in_char,
  input  logic                 in_charisk,
  input  logic                 in_disparity,
  output jesd_tx_pkg::symbol_t out_char,
  output logic                 out_disparity
);

  logic [4:0] x;      // EDCBA field.
  logic [2:0] y;      // HGF field.
  logic       k28;    // K28.x control character.
  logic [5:0] base6;  // RD- form, a at msb.
  logic [3:0] base4;  // RD- form, f at msb.
  logic [5:0] code6;
  logic [3:0] code4;
  logic       unbal6;
  logic       unbal4;
  logic       rd_mid; // Disparity between the sub-blocks.
  logic       alt7;   // Use the A7 form of x.7.
  logic [9:0] code10;

  assign x   = in_char[4:0];
  assign y   = in_char[7:5];
  assign k28 = in_charisk && (x == 5'd28);

  always_comb begin
    case (x)
      5'd0:  base6 = 6'b100111;
      5'd1:  base6 = 6'b011101;
      5'd2:  base6 = 6'b101101;
      5'd3:  base6 = 6'b110001;
      5'd4:  base6 = 6'b110101;
      5'd5:  base6 = 6'b101001;
      5'd6:  base6 = 6'b011001;
      5'd7:  base6 = 6'b111000;   // Balanced, but has an alternate.
      5'd8:  base6 = 6'b111001;
      5'd9:  base6 = 6'b100101;
      5'd10: base6 = 6'b010101;
      5'd11: base6 = 6'b110100;
      5'd12: base6 = 6'b001101;
      5'd13: base6 = 6'b101100;
      5'd14: base6 = 6'b011100;
      5'd15: base6 = 6'b010111;
      5'd16: base6 = 6'b011011;
      5'd17: base6 = 6'b100011;
      5'd18: base6 = 6'b010011;
      5'd19: base6 = 6'b110010;
      5'd20: base6 = 6'b001011;
      5'd21: base6 = 6'b101010;
      5'd22: base6 = 6'b011010;
      5'd23: base6 = 6'b111010;
      5'd24: base6 = 6'b110011;
      5'd25: base6 = 6'b100110;
      5'd26: base6 = 6'b010110;
      5'd27: base6 = 6'b110110;
      5'd28: base6 = k28 ? 6'b001111 : 6'b001110; // K28 forces the comma form.
      5'd29: base6 = 6'b101110;
      5'd30: base6 = 6'b011110;
      default: base6 = 6'b101011;
    endcase
    unbal6 = ($countones(base6) != 3);
    code6  = (in_disparity && (unbal6 || x == 5'd7)) ? ~base6 : base6;
    rd_mid = in_disparity ^ unbal6;   // Flips on an unbalanced sub-block.

    // A7 avoids a run of five equal bits across the sub-block boundary.
    alt7 = in_charisk ||
           (!rd_mid && (x == 5'd17 || x == 5'd18 || x == 5'd20)) ||
           (rd_mid && (x == 5'd11 || x == 5'd13 || x == 5'd14));
    case (y)
      3'd0:    base4 = 4'b1011;
      3'd1:    base4 = 4'b1001;
      3'd2:    base4 = 4'b0101;
      3'd3:    base4 = 4'b1100;
      3'd4:    base4 = 4'b1101;
      3'd5:    base4 = 4'b1010;
      3'd6:    base4 = 4'b0110;
      default: base4 = alt7 ? 4'b0111 : 4'b1110;
    endcase
    unbal4 = ($countones(base4) != 2);
    // K28 complements its balanced codes at RD- to keep the comma intact.
    if (unbal4 || y == 3'd3)
      code4 = rd_mid ? ~base4 : base4;
    else
      code4 = (k28 && !rd_mid) ? ~base4 : base4;

    code10 = {code6, code4};          // a .. j from msb down.
    for (int i = 0; i < 10; i++) begin
      out_char[i] = code10[9-i];      // Line order, a at bit 0.
    end
  end

  assign out_disparity = rd_mid ^ unbal4;

endmodule

/* jesd_soft_pcs_tx.sv */
// JESD204 transmit soft PCS.
// One 8b/10b encoder per octet, running disparity chained through each lane,
// optional polarity inversion and a registered symbol output.

`timescale 1ns/10ps

module jesd_soft_pcs_tx #(
  parameter int NUM_LANES       = 1,
  parameter int DATA_PATH_WIDTH = 4,
  parameter bit INVERT_OUTPUTS  = 1'b0
) (
  input  logic                                                      clk,
  input  logic                                                      reset,
  input  logic [NUM_LANES*DATA_PATH_WIDTH*jesd_tx_pkg::OCTET_W-1:0]  char,
  input  logic [NUM_LANES*DATA_PATH_WIDTH-1:0]                      charisk,
  output logic [NUM_LANES*DATA_PATH_WIDTH*jesd_tx_pkg::SYMBOL_W-1:0] data
);

  localparam int OW = jesd_tx_pkg::OCTET_W;
  localparam int SW = jesd_tx_pkg::SYMBOL_W;

  logic [NUM_LANES-1:0]              disparity;            // Per lane, 0 is RD-.
  logic [DATA_PATH_WIDTH:0]          disp_chain [NUM_LANES];
  logic [NUM_LANES*DATA_PATH_WIDTH*SW-1:0] sym;

  for (genvar lane = 0; lane < NUM_LANES; lane++) begin : gen_lane
    assign disp_chain[lane][0] = disparity[lane];          // Carried from last clock.

    always_ff @(posedge clk) begin
      if (reset) begin
        disparity[lane] <= 1'b0;                           // Start at RD-.
      end else begin
        disparity[lane] <= disp_chain[lane][DATA_PATH_WIDTH];
      end
    end

    for (genvar i = 0; i < DATA_PATH_WIDTH; i++) begin : gen_octet
      localparam int J = lane*DATA_PATH_WIDTH + i;         // Flat octet index.

      jesd_8b10b_encoder i_enc (
        .in_char       (char[J*OW +: OW]),
        .in_charisk    (charisk[J]),
        .in_disparity  (disp_chain[lane][i]),
        .out_char      (sym[J*SW +: SW]),
        .out_disparity (disp_chain[lane][i+1])             // Feeds the next octet.
      );
    end
  end

  // Symbol register, polarity swap for inverted board traces.
  always_ff @(posedge clk) begin
    data <= INVERT_OUTPUTS ? ~sym : sym;
  end

endmodule

/* jesd_tx_scrambler.sv */
// JESD204 transmit scrambler.
// Self-synchronous 1 + x^14 + x^15 per lane, run-time enable, registered output.

`timescale 1ns/10ps

module jesd_tx_scrambler #(
  parameter int NUM_LANES       = 1,
  parameter int DATA_PATH_WIDTH = 4
) (
  input  logic                                                     clk,
  input  logic                                                     reset,
  input  logic                                                     scramble_en,
  input  logic [NUM_LANES*DATA_PATH_WIDTH*jesd_tx_pkg::OCTET_W-1:0] char,
  output logic [NUM_LANES*DATA_PATH_WIDTH*jesd_tx_pkg::OCTET_W-1:0] scr_char
);

  localparam int OW = jesd_tx_pkg::OCTET_W;

  logic [14:0] hist_q [NUM_LANES];                        // Bit 0 is the newest.
  logic [14:0] hist_d [NUM_LANES];
  logic [NUM_LANES*DATA_PATH_WIDTH*OW-1:0] scr_d;

  always_comb begin
    logic [14:0] hist;
    logic        bit_in;
    logic        bit_out;
    for (int l = 0; l < NUM_LANES; l++) begin
      hist = hist_q[l];
      // Octet 0 first, msb first within the octet.
      for (int j = 0; j < DATA_PATH_WIDTH; j++) begin
        for (int b = OW-1; b >= 0; b--) begin
          bit_in  = char[(l*DATA_PATH_WIDTH + j)*OW + b];
          bit_out = scramble_en ? (bit_in ^ hist[13] ^ hist[14]) : bit_in; // Taps 14, 15.
          scr_d[(l*DATA_PATH_WIDTH + j)*OW + b] = bit_out;
          hist = {hist[13:0], bit_out};                   // Raw bits when bypassed.
        end
      end
      hist_d[l] = hist;
    end
  end

  always_ff @(posedge clk) begin
    for (int l = 0; l < NUM_LANES; l++) begin
      if (reset) begin
        hist_q[l] <= '0;                                  // Known seed.
      end else begin
        hist_q[l] <= hist_d[l];
      end
    end
  end

  always_ff @(posedge clk) begin
    scr_char <= scr_d;
  end

endmodule

/* jesd_tx_link_ctrl.sv */
// JESD204 transmit link controller.
// Sends K28.5 on every octet while the receiver requests sync, user data
// otherwise, with registered characters and K flags.

`timescale 1ns/10ps

module jesd_tx_link_ctrl #(
  parameter int NUM_LANES       = 1,
  parameter int DATA_PATH_WIDTH = 4
) (
  input  logic                                                     clk,
  input  logic                                                     reset,
  input  logic                                                     sync_req,
  input  logic [NUM_LANES*DATA_PATH_WIDTH*jesd_tx_pkg::OCTET_W-1:0] scr_char,
  output logic [NUM_LANES*DATA_PATH_WIDTH*jesd_tx_pkg::OCTET_W-1:0] pcs_char,
  output logic [NUM_LANES*DATA_PATH_WIDTH-1:0]                     pcs_charisk
);

  localparam int NUM_OCTETS = NUM_LANES*DATA_PATH_WIDTH;

  logic [NUM_OCTETS*jesd_tx_pkg::OCTET_W-1:0] cgs_char;  // All-comma word.
  logic                                       in_cgs;    // Code group sync phase.

  assign cgs_char = {NUM_OCTETS{jesd_tx_pkg::K28_5}};
  assign in_cgs   = sync_req;                             // Request wins at once.

  // Registered character mux, reset enters code group sync.
  always_ff @(posedge clk) begin
    if (reset) begin
      pcs_char    <= cgs_char;
      pcs_charisk <= '1;
    end else if (in_cgs) begin
      pcs_char    <= cgs_char;                            // K28.5 everywhere.
      pcs_charisk <= '1;
    end else begin
      pcs_char    <= scr_char;                            // Data characters.
      pcs_charisk <= '0;
    end
  end

endmodule

/* jesd_tx_top.sv */
// JESD204 transmit datapath top.
// Scrambler, link controller and soft PCS in a three-stage pipeline.

`timescale 1ns/10ps

module jesd_tx_top #(
  parameter int NUM_LANES       = jesd_tx_pkg::NUM_LANES_DEF,
  parameter int DATA_PATH_WIDTH = jesd_tx_pkg::DPW_DEF,
  parameter bit INVERT_OUTPUTS  = 1'b0
) (
  input  logic                                                      clk,
  input  logic                                                      reset,
  input  logic                                                      sync_req,
  input  logic                                                      scramble_en,
  input  logic [NUM_LANES*DATA_PATH_WIDTH*jesd_tx_pkg::OCTET_W-1:0]  char,
  output logic [NUM_LANES*DATA_PATH_WIDTH*jesd_tx_pkg::SYMBOL_W-1:0] data
);

  logic [NUM_LANES*DATA_PATH_WIDTH*jesd_tx_pkg::OCTET_W-1:0] scr_char;    // Stage 1 out.
  logic [NUM_LANES*DATA_PATH_WIDTH*jesd_tx_pkg::OCTET_W-1:0] pcs_char;    // Stage 2 out.
  logic [NUM_LANES*DATA_PATH_WIDTH-1:0]                      pcs_charisk;

  jesd_tx_scrambler #(
    .NUM_LANES       (NUM_LANES),
    .DATA_PATH_WIDTH (DATA_PATH_WIDTH)
  ) i_scrambler (
    .clk         (clk),
    .reset       (reset),
    .scramble_en (scramble_en),
    .char        (char),
    .scr_char    (scr_char)
  );

  jesd_tx_link_ctrl #(
    .NUM_LANES       (NUM_LANES),
    .DATA_PATH_WIDTH (DATA_PATH_WIDTH)
  ) i_link_ctrl (
    .clk         (clk),
    .reset       (reset),
    .sync_req    (sync_req),                // Bypasses the scrambler stage.
    .scr_char    (scr_char),
    .pcs_char    (pcs_char),
    .pcs_charisk (pcs_charisk)
  );

  jesd_soft_pcs_tx #(
    .NUM_LANES       (NUM_LANES),
    .DATA_PATH_WIDTH (DATA_PATH_WIDTH),
    .INVERT_OUTPUTS  (INVERT_OUTPUTS)
  ) i_soft_pcs (
    .clk     (clk),
    .reset   (reset),
    .char    (pcs_char),
    .charisk (pcs_charisk),
    .data    (data)
  );

endmodule

/* jesd_tx_checker.sv */
// Assertions on the JESD204 transmit output.
// Bound into the top level, checks symbol weight, unknown bits and sync commas.

`timescale 1ns/10ps

module jesd_tx_checker #(
  parameter int NUM_SYMBOLS = 16
) (
  input logic                                          clk,
  input logic                                          reset,
  input logic                                          sync_req,
  input logic [NUM_SYMBOLS*jesd_tx_pkg::SYMBOL_W-1:0]  data
);

  localparam int SW = jesd_tx_pkg::SYMBOL_W;

  int   fail_count = 0;   // Tally of assertion failures.
  logic all_k28;          // Every symbol is a K28.5 code group.
  logic all_weight_ok;    // Every symbol has 4 to 6 ones.

  always_comb begin
    all_k28       = 1'b1;
    all_weight_ok = 1'b1;
    for (int i = 0; i < NUM_SYMBOLS; i++) begin
      if (data[i*SW +: SW] != jesd_tx_pkg::K28_5_RDN &&
          data[i*SW +: SW] != jesd_tx_pkg::K28_5_RDP) begin
        all_k28 = 1'b0;
      end
      if ($countones(data[i*SW +: SW]) < 4 || $countones(data[i*SW +: SW]) > 6) begin
        all_weight_ok = 1'b0;                             // Not a valid 8b/10b weight.
      end
    end
  end

  a_no_x: assert property (@(posedge clk) disable iff (reset) !$isunknown(data))
    else begin
      $error("data has unknown bits after reset");
      fail_count++;
    end

  a_weight: assert property (@(posedge clk) disable iff (reset) all_weight_ok)
    else begin
      $error("data holds a symbol with a bad number of ones");
      fail_count++;
    end

  // Two cycles of latency, so three samples of sync_req cover the word on data.
  a_cgs: assert property (@(posedge clk) disable iff (reset)
    (sync_req && $past(sync_req) && $past(sync_req, 2)) |-> all_k28)
    else begin
      $error("data holds a non-K28.5 symbol during code group sync");
      fail_count++;
    end

endmodule

/* tb_jesd_tx_top.sv */
// Testbench for the JESD204 transmit datapath.
// Runs sync, plain, disparity, scrambled and resync traffic through the DUT
// and decodes every output symbol with a reference 8b/10b decoder.

`timescale 1ns/10ps

module tb_jesd_tx_top;

  localparam int NL           = jesd_tx_pkg::NUM_LANES_DEF;
  localparam int DPW          = jesd_tx_pkg::DPW_DEF;
  localparam int NO           = NL*DPW;                  // Octets per word.
  localparam int OW           = jesd_tx_pkg::OCTET_W;
  localparam int SW           = jesd_tx_pkg::SYMBOL_W;
  localparam int CLK_PERIOD   = 4;
  localparam int RESET_CYCLES = 5;
  localparam int N_SYNC       = 8;
  localparam int N_PLAIN      = 24;
  localparam int N_DISP       = 32;                      // 8 corner words and 24 random.
  localparam int N_SCR        = 24;
  localparam int N_RESYNC     = 10;
  localparam int TOTAL_CYCLES = RESET_CYCLES + N_SYNC + N_PLAIN + N_DISP + N_SCR + N_RESYNC;

  // 5b/6b codes at RD- in abcdei order with a as msb.
  localparam logic [5:0] TAB6 [32] = '{
    6'b100111, 6'b011101, 6'b101101, 6'b110001, 6'b110101, 6'b101001, 6'b011001, 6'b111000,
    6'b111001, 6'b100101, 6'b010101, 6'b110100, 6'b001101, 6'b101100, 6'b011100, 6'b010111,
    6'b011011, 6'b100011, 6'b010011, 6'b110010, 6'b001011, 6'b101010, 6'b011010, 6'b111010,
    6'b110011, 6'b100110, 6'b010110, 6'b110110, 6'b001110, 6'b101110, 6'b011110, 6'b101011
  };
  // 3b/4b codes at RD- in fghj order with f as msb. Entry 8 is the A7 form.
  localparam logic [3:0] TAB4 [9] = '{
    4'b1011, 4'b1001, 4'b0101, 4'b1100, 4'b1101, 4'b1010, 4'b0110, 4'b1110, 4'b0111
  };

  logic             clk;
  logic             reset;
  logic             sync_req;
  logic             scramble_en;
  logic [NO*OW-1:0] char;
  logic [NO*SW-1:0] data;
  int               seed = 89937;
  int               n_checks;
  int               n_errors;
  string            cur_test;
  logic [14:0]      lane_hist [NL];                      // Bit 0 is the newest bit.
  logic [NO*OW-1:0] scr_pipe [3];                        // Expected words in flight.
  logic             sreq_pipe [2];
  logic             ref_rd [NL];                         // Decoder disparity where 1 is RD+.

  jesd_tx_top #(
    .NUM_LANES       (NL),
    .DATA_PATH_WIDTH (DPW),
    .INVERT_OUTPUTS  (1'b0)
  ) uut (
    .clk         (clk),
    .reset       (reset),
    .sync_req    (sync_req),
    .scramble_en (scramble_en),
    .char        (char),
    .data        (data)
  );

  bind jesd_tx_top jesd_tx_checker #(
    .NUM_SYMBOLS (NUM_LANES*DATA_PATH_WIDTH)
  ) i_checker (
    .clk      (clk),
    .reset    (reset),
    .sync_req (sync_req),
    .data     (data)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD/2) clk = ~clk;
  end

  // Watchdog ends the run at half again the total test length.
  initial begin
    #(TOTAL_CYCLES * CLK_PERIOD * 3 / 2);
    $display("Timeout: the tests did not finish within %0d cycles", TOTAL_CYCLES * 3 / 2);
    $display("Checks failed");
    $finish;
  end

  // Decodes one code group at running disparity rd. Returns 0 if it is invalid.
  function automatic logic decode_symbol(input jesd_tx_pkg::symbol_t s, input logic rd,
                                         output jesd_tx_pkg::octet_t oct, output logic k,
                                         output logic rd_next);
    logic [5:0] c6;
    logic [3:0] c4;
    logic [5:0] e6;
    logic [3:0] e4;
    logic       rd_mid;
    logic       hit6;
    logic       hit4;
    logic       a7;
    c6      = {s[0], s[1], s[2], s[3], s[4], s[5]};      // abcdei.
    c4      = {s[6], s[7], s[8], s[9]};                  // fghj.
    oct     = '0;
    k       = 1'b0;
    rd_mid  = rd;
    rd_next = rd;
    hit6    = 1'b0;
    hit4    = 1'b0;
    for (int x = 0; x <= 32; x++) begin
      e6 = (x == 32) ? 6'b001111 : TAB6[x];              // Index 32 is the K28 comma.
      e6 = (rd && ($countones(e6) != 3 || x == 7)) ? ~e6 : e6;
      if (!hit6 && e6 == c6) begin
        hit6     = 1'b1;
        k        = (x == 32);
        oct[4:0] = (x == 32) ? 5'd28 : 5'(x);
        rd_mid   = rd ^ ($countones(e6) != 3);
      end
    end
    // A7 replaces P7 on K28 and where P7 would run five equal bits from e to h.
    a7 = k || (c6[1:0] == {2{!rd_mid}});
    for (int y = 0; y < 9; y++) begin
      e4 = TAB4[y];
      // K28 also flips its balanced codes at RD-.
      e4 = (($countones(e4) != 2 || y == 3) ? rd_mid : (k && !rd_mid)) ? ~e4 : e4;
      if (!hit4 && e4 == c4 && (y < 7 || (y == 8) == a7)) begin
        hit4     = 1'b1;
        oct[7:5] = (y == 8) ? 3'd7 : 3'(y);
        rd_next  = rd_mid ^ ($countones(e4) != 2);
      end
    end
    return hit6 && hit4;
  endfunction

  // Scrambler model with taps at delays 14 and 15, msb first and octet 0 first.
  function automatic logic [NO*OW-1:0] scramble_word(input logic [NO*OW-1:0] w, input logic en);
    logic [NO*OW-1:0] s;
    logic             b;
    for (int l = 0; l < NL; l++) begin
      for (int j = 0; j < DPW; j++) begin
        for (int i = OW-1; i >= 0; i--) begin
          b = w[(l*DPW + j)*OW + i];
          b = en ? (b ^ lane_hist[l][13] ^ lane_hist[l][14]) : b;
          s[(l*DPW + j)*OW + i] = b;
          lane_hist[l] = {lane_hist[l][13:0], b};
        end
      end
    end
    return s;
  endfunction

  function automatic logic [NO*OW-1:0] random_word();
    logic [NO*OW-1:0] w;
    for (int i = 0; i < NO; i++) begin
      w[i*OW +: OW] = jesd_tx_pkg::octet_t'($random(seed));
    end
    return w;
  endfunction

  task automatic check_octet(input string name, input jesd_tx_pkg::octet_t exp,
                             input logic exp_k, input jesd_tx_pkg::octet_t act,
                             input logic act_k);
    n_checks++;
    if (exp !== act || exp_k !== act_k) begin
      n_errors++;
      $display("FAILED %s: expected %h k=%0b, actual %h k=%0b", name, exp, exp_k, act, act_k);
    end
  endtask

  task automatic check_symbol(input string name, input jesd_tx_pkg::symbol_t exp,
                              input jesd_tx_pkg::symbol_t act);
    n_checks++;
    if (exp !== act) begin
      n_errors++;
      $display("FAILED %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  // Drives one word per clock and checks what the PCS sends in the same cycle.
  task automatic step(input logic [NO*OW-1:0] w, input logic sreq, input logic sen);
    logic [NO*OW-1:0]     exp_word;
    logic                 exp_cgs;
    jesd_tx_pkg::symbol_t sym;
    jesd_tx_pkg::octet_t  oct;
    logic                 k;
    logic                 ok;
    logic                 rd_next;
    string                where;
    @(posedge clk);
    char        <= w;
    sync_req    <= sreq;
    scramble_en <= sen;
    exp_cgs      = sreq_pipe[1];                         // sync_req leads data by 2.
    exp_word     = scr_pipe[2];                          // char leads data by 3.
    sreq_pipe[1] = sreq_pipe[0];
    sreq_pipe[0] = sreq;
    scr_pipe[2]  = scr_pipe[1];
    scr_pipe[1]  = scr_pipe[0];
    scr_pipe[0]  = scramble_word(w, sen);
    @(negedge clk);
    for (int l = 0; l < NL; l++) begin
      for (int j = 0; j < DPW; j++) begin
        sym   = data[(l*DPW + j)*SW +: SW];
        where = $sformatf("%s lane %0d octet %0d", cur_test, l, j);
        ok    = decode_symbol(sym, ref_rd[l], oct, k, rd_next);
        if (!ok) begin
          n_errors++;
          $display("Invalid code group %b at RD%s in %s", sym, ref_rd[l] ? "+" : "-", where);
        end else if (exp_cgs) begin
          check_symbol(where, ref_rd[l] ? jesd_tx_pkg::K28_5_RDP : jesd_tx_pkg::K28_5_RDN, sym);
        end else begin
          check_octet(where, exp_word[(l*DPW + j)*OW +: OW], 1'b0, oct, k);
        end
        ref_rd[l] = rd_next;                             // Carries across clocks.
      end
    end
  endtask

  task automatic report_test(input int errs_before);
    $display("Test %s done, %0d errors", cur_test, n_errors - errs_before);
  endtask

  task automatic test_cgs();
    int e0;
    e0       = n_errors;
    cur_test = "cgs";
    repeat (N_SYNC) step('0, 1'b1, 1'b0);
    report_test(e0);
  endtask

  task automatic test_plain();
    int e0;
    e0       = n_errors;
    cur_test = "plain";
    repeat (N_PLAIN) step(random_word(), 1'b0, 1'b0);
    report_test(e0);
  endtask

  task automatic test_disparity();
    jesd_tx_pkg::octet_t corner [8];
    int                  e0;
    corner   = '{8'hF1, 8'hF2, 8'hF4, 8'hEB, 8'hED, 8'hEE, 8'h07, 8'hFF}; // D.x.7 cases.
    e0       = n_errors;
    cur_test = "rd";
    for (int i = 0; i < 8; i++) begin
      step({NO{corner[i]}}, 1'b0, 1'b0);
    end
    repeat (N_DISP - 8) step(random_word(), 1'b0, 1'b0);
    report_test(e0);
  endtask

  task automatic test_scramble();
    int e0;
    e0       = n_errors;
    cur_test = "scramble";
    repeat (N_SCR) step(random_word(), 1'b0, 1'b1);
    report_test(e0);
  endtask

  task automatic test_resync();
    int e0;
    e0       = n_errors;
    cur_test = "resync";
    repeat (N_RESYNC) step(random_word(), 1'b1, 1'b1);
    report_test(e0);
  endtask

  initial begin
    reset       = 1'b1;
    sync_req    = 1'b1;
    scramble_en = 1'b0;
    char        = '0;
    n_checks    = 0;
    n_errors    = 0;
    for (int l = 0; l < NL; l++) begin
      lane_hist[l] = '0;                                 // Scrambler seed after reset.
      ref_rd[l]    = 1'b0;
    end
    for (int i = 0; i < 3; i++) begin
      scr_pipe[i] = '0;
    end
    sreq_pipe[0] = 1'b1;                                 // Reset acts as a sync request.
    sreq_pipe[1] = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    reset <= 1'b0;
    test_cgs();
    test_plain();
    test_disparity();
    test_scramble();
    test_resync();
    n_errors += uut.i_checker.fail_count;
    $display("Total: %0d checks, %0d errors", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

/* jesd_tx_top.f */
jesd_tx_pkg.sv
jesd_8b10b_encoder.sv
jesd_soft_pcs_tx.sv
jesd_tx_scrambler.sv
jesd_tx_link_ctrl.sv
jesd_tx_top.sv
jesd_tx_checker.sv
tb_jesd_tx_top.sv

/* run_sim.sh */
#!/bin/sh
# Compile and run the JESD204 transmit testbench with Verilator.
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module tb_jesd_tx_top -f jesd_tx_top.f
./obj_dir/Vtb_jesd_tx_top +verilator+error+limit+1000 | tee sim.log

if grep -q "Checks failed" sim.log; then
  echo "Simulation FAILED"
  exit 1
fi
if ! grep -q "All checks passed" sim.log; then
  echo "Simulation ended without a result"
  exit 1
fi
echo "Simulation PASSED"
